// File: src/act_defines.svh
// widths and depths for the activation input path
// include wherever a width or buffer depth is needed

`ifndef ACT_DEFINES_SVH
`define ACT_DEFINES_SVH

// ====================
// data widths
// ====================

// host bus and buffer word
`define PORT_WIDTH 96

// one activation
`define DATA_WIDTH 8

// channels per block, also flag bits per block
`define BLOCK_DEPTH 12

// ====================
// buffer depths
// ====================

`define ACT_ADDR_WIDTH 4
`define FLG_ADDR_WIDTH 3

`endif

// File: src/act_pkg.sv
// shared data types of the activation input path
// modules pull these in with a wildcard import

`default_nettype none

`include "act_defines.svh"

package act_pkg;

    // ====================
    // buffer side
    // ====================

    // one word as written by the host
    typedef logic [`PORT_WIDTH-1:0] port_word_t;

    // ====================
    // block side
    // ====================

    typedef logic [`DATA_WIDTH-1:0] act_t;

    // bit i set means channel i holds a non-zero value
    typedef logic [`BLOCK_DEPTH-1:0] flag_blk_t;

    // channel i in element i, channel 0 in the low bits
    typedef logic [`BLOCK_DEPTH-1:0][`DATA_WIDTH-1:0] dense_blk_t;

endpackage

`default_nettype wire

// File: src/act_gbf.sv
// global buffer for one stream of packed words
// host writes at its own addresses and words go out to an unpacker
// a fetch fires on the rising edge of space and readable

`timescale 1ns/1ps
`default_nettype none

module act_gbf import act_pkg::*; #(
    parameter int ADDR_WIDTH = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clear,
    input  logic                  en_wr,
    input  logic [ADDR_WIDTH-1:0] addr_wr,
    input  port_word_t            dat_wr,
    input  logic                  space,
    output logic                  word_en,
    output port_word_t            word
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;
    localparam logic [ADDR_WIDTH:0] FULL_CNT = (ADDR_WIDTH + 1)'(DEPTH);

    port_word_t            mem [DEPTH];
    logic [ADDR_WIDTH:0]   fill_cnt;
    logic [ADDR_WIDTH-1:0] addr_rd;
    logic                  readable;
    logic                  fetch_ok;
    logic                  fetch_ok_d;
    logic                  en_rd;
    // entries written and not yet read
    logic [DEPTH-1:0]      unread;

    // single port so a write in this cycle blocks the read
    assign readable = (fill_cnt != '0) && !en_wr;
    assign fetch_ok = space && readable;

    // one read per rising edge only
    assign en_rd = fetch_ok && !fetch_ok_d;

    // ====================
    // storage
    // ====================

    always_ff @(posedge clk) begin
        if (en_wr) begin
            mem[addr_wr] <= dat_wr;
        end
        if (en_rd) begin
            word <= mem[addr_rd];
        end
    end

    // ====================
    // fill and read tracking
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_cnt   <= '0;
            addr_rd    <= '0;
            fetch_ok_d <= 1'b0;
            word_en    <= 1'b0;
            unread     <= '0;
        end else if (clear) begin
            fill_cnt   <= '0;
            addr_rd    <= '0;
            fetch_ok_d <= 1'b0;
            word_en    <= 1'b0;
            unread     <= '0;
        end else begin
            fetch_ok_d <= fetch_ok;
            // data is out one cycle after the read
            word_en    <= en_rd;
            if (en_wr) begin
                fill_cnt        <= fill_cnt + 1'b1;
                unread[addr_wr] <= 1'b1;
            end else if (en_rd) begin
                fill_cnt        <= fill_cnt - 1'b1;
                unread[addr_rd] <= 1'b0;
            end
            if (en_rd) begin
                addr_rd <= addr_rd + 1'b1;
            end
        end
    end

    // host must respect the unread space
    assert property (@(posedge clk) disable iff (!rst_n)
        en_wr |-> fill_cnt != FULL_CNT)
        else $error("write into a full buffer");

    // a fetch must find a written entry at the read address
    assert property (@(posedge clk) disable iff (!rst_n)
        en_rd |-> unread[addr_rd])
        else $error("fetch from an empty buffer");

endmodule

`default_nettype wire

// File: src/word_unpacker.sv
// splits one buffer word into equal elements
// the most significant element goes out first, one per get

`timescale 1ns/1ps
`default_nettype none

`include "act_defines.svh"

module word_unpacker import act_pkg::*; #(
    parameter int ELEM_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clear,
    output logic                  space,
    input  logic                  word_en,
    input  port_word_t            word,
    output logic                  elem_rdy,
    input  logic                  elem_get,
    output logic [ELEM_WIDTH-1:0] elem
);

    localparam int NUM_ELEM  = `PORT_WIDTH / ELEM_WIDTH;
    localparam int CNT_WIDTH = $clog2(NUM_ELEM + 1);

    port_word_t           hold_q;
    logic [CNT_WIDTH-1:0] left_cnt;
    logic                 take;

    // empty once every element has been taken
    assign space    = (left_cnt == '0);
    assign elem_rdy = !space;
    assign take     = elem_get && elem_rdy;
    assign elem     = hold_q[`PORT_WIDTH-1 -: ELEM_WIDTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            left_cnt <= '0;
        end else if (clear) begin
            left_cnt <= '0;
        end else if (word_en) begin
            left_cnt <= CNT_WIDTH'(NUM_ELEM);
        end else if (take) begin
            left_cnt <= left_cnt - 1'b1;
        end
    end

    // ====================
    // left shift register
    // ====================

    always_ff @(posedge clk) begin
        if (word_en) begin
            hold_q <= word;
        end else if (take) begin
            hold_q <= hold_q << ELEM_WIDTH;
        end
    end

    // buffer may only deliver into an empty unpacker
    assert property (@(posedge clk) disable iff (!rst_n)
        word_en |-> space)
        else $error("word arrived while a word is still held");

endmodule

`default_nettype wire

// File: src/block_assembler.sv
// builds dense activation blocks from a flag stream and packed values
// each set flag bit pulls one activation, clear bits stay zero
// a finished block is held until the consumer pulses blk_get

`timescale 1ns/1ps
`default_nettype none

`include "act_defines.svh"

module block_assembler import act_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear,
    input  logic       flg_rdy,
    output logic       flg_get,
    input  flag_blk_t  flg,
    input  logic       act_rdy,
    output logic       act_get,
    input  act_t       act,
    input  logic       blk_get,
    output logic       blk_rdy,
    output dense_blk_t blk_dat,
    output flag_blk_t  blk_flag
);

    localparam int CH_WIDTH = $clog2(`BLOCK_DEPTH);

    typedef enum logic [2:0] {
        ST_FLAG,
        ST_FLAG_TAKE,
        ST_WALK,
        ST_ACT_TAKE,
        ST_HOLD
    } state_t;

    state_t              state;
    logic [CH_WIDTH-1:0] ch;
    logic                last_ch;
    flag_blk_t           flag_q;
    dense_blk_t          dense_q;

    assign last_ch  = (ch == CH_WIDTH'(`BLOCK_DEPTH - 1));
    assign blk_rdy  = (state == ST_HOLD);
    assign blk_dat  = dense_q;
    assign blk_flag = flag_q;

    // ====================
    // FSM
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_FLAG;
            ch      <= '0;
            flg_get <= 1'b0;
            act_get <= 1'b0;
        end else if (clear) begin
            state   <= ST_FLAG;
            ch      <= '0;
            flg_get <= 1'b0;
            act_get <= 1'b0;
        end else begin
            case (state)
                ST_FLAG: begin
                    if (flg_rdy) begin
                        flg_get <= 1'b1;
                        state   <= ST_FLAG_TAKE;
                    end
                end
                ST_FLAG_TAKE: begin
                    flg_get <= 1'b0;
                    ch      <= '0;
                    state   <= ST_WALK;
                end
                ST_WALK: begin
                    // zero channel, nothing to pull
                    if (!flag_q[ch]) begin
                        ch    <= ch + 1'b1;
                        state <= last_ch ? ST_HOLD : ST_WALK;
                    end else if (act_rdy) begin
                        act_get <= 1'b1;
                        state   <= ST_ACT_TAKE;
                    end
                end
                ST_ACT_TAKE: begin
                    act_get <= 1'b0;
                    ch      <= ch + 1'b1;
                    state   <= last_ch ? ST_HOLD : ST_WALK;
                end
                ST_HOLD: begin
                    if (blk_get) begin
                        state <= ST_FLAG;
                    end
                end
                default: state <= ST_FLAG;
            endcase
        end
    end

    // block contents, captured while the matching get is high
    always_ff @(posedge clk) begin
        if (state == ST_FLAG_TAKE) begin
            flag_q  <= flg;
            dense_q <= '0;
        end else if (state == ST_ACT_TAKE) begin
            dense_q[ch] <= act;
        end
    end

    // a registered get must still find its element waiting
    assert property (@(posedge clk) disable iff (!rst_n)
        (flg_get |-> flg_rdy) and (act_get |-> act_rdy))
        else $error("get issued without a ready element");

endmodule

`default_nettype wire

// File: src/act_dispatch_top.sv
// activation input path top level
// host fills the flag and activation buffers, dense blocks come out
// under blk_rdy and are released by a blk_get pulse

`timescale 1ns/1ps
`default_nettype none

`include "act_defines.svh"

module act_dispatch_top import act_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       layer_clr,
    input  logic                       act_en_wr,
    input  logic [`ACT_ADDR_WIDTH-1:0] act_addr_wr,
    input  port_word_t                 act_dat_wr,
    input  logic                       flg_en_wr,
    input  logic [`FLG_ADDR_WIDTH-1:0] flg_addr_wr,
    input  port_word_t                 flg_dat_wr,
    input  logic                       blk_get,
    output logic                       blk_rdy,
    output dense_blk_t                 blk_dat,
    output flag_blk_t                  blk_flag
);

    // ====================
    // buffer to unpacker
    // ====================

    logic       act_space;
    logic       act_word_en;
    port_word_t act_word;
    logic       flg_space;
    logic       flg_word_en;
    port_word_t flg_word;

    // unpacker to assembler
    logic       act_elem_rdy;
    logic       act_elem_get;
    act_t       act_elem;
    logic       flg_elem_rdy;
    logic       flg_elem_get;
    flag_blk_t  flg_elem;

    // ====================
    // input side
    // ====================

    act_gbf #(.ADDR_WIDTH(`ACT_ADDR_WIDTH)) gbf_act (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear   (layer_clr),
        .en_wr   (act_en_wr),
        .addr_wr (act_addr_wr),
        .dat_wr  (act_dat_wr),
        .space   (act_space),
        .word_en (act_word_en),
        .word    (act_word)
    );

    act_gbf #(.ADDR_WIDTH(`FLG_ADDR_WIDTH)) gbf_flg (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear   (layer_clr),
        .en_wr   (flg_en_wr),
        .addr_wr (flg_addr_wr),
        .dat_wr  (flg_dat_wr),
        .space   (flg_space),
        .word_en (flg_word_en),
        .word    (flg_word)
    );

    // ====================
    // processing
    // ====================

    word_unpacker #(.ELEM_WIDTH(`DATA_WIDTH)) unpack_act (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (layer_clr),
        .space    (act_space),
        .word_en  (act_word_en),
        .word     (act_word),
        .elem_rdy (act_elem_rdy),
        .elem_get (act_elem_get),
        .elem     (act_elem)
    );

    word_unpacker #(.ELEM_WIDTH(`BLOCK_DEPTH)) unpack_flg (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (layer_clr),
        .space    (flg_space),
        .word_en  (flg_word_en),
        .word     (flg_word),
        .elem_rdy (flg_elem_rdy),
        .elem_get (flg_elem_get),
        .elem     (flg_elem)
    );

    // output side
    block_assembler assembler (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (layer_clr),
        .flg_rdy  (flg_elem_rdy),
        .flg_get  (flg_elem_get),
        .flg      (flg_elem),
        .act_rdy  (act_elem_rdy),
        .act_get  (act_elem_get),
        .act      (act_elem),
        .blk_get  (blk_get),
        .blk_rdy  (blk_rdy),
        .blk_dat  (blk_dat),
        .blk_flag (blk_flag)
    );

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
// clock and reset source for the testbench
// reset is released a short time after a rising edge

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #10;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: verification/tb_act_dispatch.sv
// directed tests for the activation input path
// a host model fills both buffers, each block is checked against a packing model

`timescale 1ns/1ps
`default_nettype none

`include "act_defines.svh"

module tb_act_dispatch import act_pkg::*; ();

    localparam int FLG_PER_WORD = `PORT_WIDTH / `BLOCK_DEPTH;
    localparam int ACT_PER_WORD = `PORT_WIDTH / `DATA_WIDTH;
    // words written over all tests, sparse tests at their largest
    localparam int WORDS_WRITTEN = 9 + 18 + 3 + 9 + 18;
    localparam int CYCLE_LIMIT   = 40 * WORDS_WRITTEN + 200;

    logic                       clk;
    logic                       rst_n;
    logic                       layer_clr;
    logic                       act_en_wr;
    logic [`ACT_ADDR_WIDTH-1:0] act_addr_wr;
    port_word_t                 act_dat_wr;
    logic                       flg_en_wr;
    logic [`FLG_ADDR_WIDTH-1:0] flg_addr_wr;
    port_word_t                 flg_dat_wr;
    logic                       blk_get;
    logic                       blk_rdy;
    dense_blk_t                 blk_dat;
    flag_blk_t                  blk_flag;

    logic [15:0] lfsr_q;
    int          cycle_cnt = 0;
    flag_blk_t   flag_list[$];
    act_t        act_list[$];
    dense_blk_t  exp_dat_q[$];

    tb_clock_gen #(.PERIOD(100), .RST_CYCLES(16)) clk_gen (.clk(clk), .rst_n(rst_n));

    act_dispatch_top dut0 (.*);

    // ====================
    // checks
    // ====================

    task automatic fail_and_stop(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_block(input dense_blk_t got, input dense_blk_t exp, input string what);
        if (got !== exp) begin
            fail_and_stop($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input flag_blk_t got, input flag_blk_t exp, input string what);
        if (got !== exp) begin
            fail_and_stop($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_and_stop($sformatf("ERR %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            fail_and_stop($sformatf("timeout: no finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    // ====================
    // stimulus helpers
    // ====================

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val    = {val[30:0], lfsr_q[0]};
        end
    endtask

    // and of two draws, roughly a quarter of the bits set
    task automatic rand_flags(input int n);
        logic [31:0] r1;
        logic [31:0] r2;
        for (int b = 0; b < n; b++) begin
            rand_bits(`BLOCK_DEPTH, r1);
            rand_bits(`BLOCK_DEPTH, r2);
            flag_list.push_back(r1[`BLOCK_DEPTH-1:0] & r2[`BLOCK_DEPTH-1:0]);
        end
    endtask

    // one random activation per set flag bit
    task automatic cover_flags();
        logic [31:0] r;
        foreach (flag_list[b]) begin
            for (int i = 0; i < $countones(flag_list[b]); i++) begin
                rand_bits(`DATA_WIDTH, r);
                act_list.push_back(r[`DATA_WIDTH-1:0]);
            end
        end
    endtask

    task automatic clear_layer();
        layer_clr = 1'b1;
        next_cycle();
        layer_clr = 1'b0;
        flag_list.delete();
        act_list.delete();
    endtask

    // model of the block rule, then host writes from address 0
    task automatic load_stream();
        dense_blk_t blk;
        port_word_t w;
        int         ai;
        ai = 0;
        exp_dat_q.delete();
        foreach (flag_list[b]) begin
            blk = '0;
            for (int c = 0; c < `BLOCK_DEPTH; c++) begin
                if (flag_list[b][c]) begin
                    blk[c] = act_list[ai];
                    ai++;
                end
            end
            exp_dat_q.push_back(blk);
        end
        // first element in the top bits, short last word padded with zeros
        for (int i = 0; i * FLG_PER_WORD < flag_list.size(); i++) begin
            w = '0;
            for (int j = 0; j < FLG_PER_WORD && i * FLG_PER_WORD + j < flag_list.size(); j++) begin
                w[`PORT_WIDTH-1-j*`BLOCK_DEPTH -: `BLOCK_DEPTH] = flag_list[i*FLG_PER_WORD+j];
            end
            flg_en_wr   = 1'b1;
            flg_addr_wr = i[`FLG_ADDR_WIDTH-1:0];
            flg_dat_wr  = w;
            next_cycle();
        end
        flg_en_wr = 1'b0;
        for (int i = 0; i * ACT_PER_WORD < act_list.size(); i++) begin
            w = '0;
            for (int j = 0; j < ACT_PER_WORD && i * ACT_PER_WORD + j < act_list.size(); j++) begin
                w[`PORT_WIDTH-1-j*`DATA_WIDTH -: `DATA_WIDTH] = act_list[i*ACT_PER_WORD+j];
            end
            act_en_wr   = 1'b1;
            act_addr_wr = i[`ACT_ADDR_WIDTH-1:0];
            act_dat_wr  = w;
            next_cycle();
        end
        act_en_wr = 1'b0;
    endtask

    task automatic take_block(input int b);
        while (blk_rdy !== 1'b1) begin
            next_cycle();
        end
        check_block(blk_dat, exp_dat_q[b], $sformatf("blk_dat of block %0d", b));
        check_flag(blk_flag, flag_list[b], $sformatf("blk_flag of block %0d", b));
        blk_get = 1'b1;
        next_cycle();
        blk_get = 1'b0;
        check_level(blk_rdy, 1'b0, "blk_rdy after blk_get");
    endtask

    task automatic drain_blocks(input int first);
        for (int b = first; b < flag_list.size(); b++) begin
            take_block(b);
        end
    endtask

    // ====================
    // tests
    // ====================

    task automatic test_idle();
        repeat (50) begin
            check_level(blk_rdy, 1'b0, "blk_rdy with empty buffers");
            next_cycle();
        end
    endtask

    task automatic test_dense();
        clear_layer();
        repeat (FLG_PER_WORD) flag_list.push_back({`BLOCK_DEPTH{1'b1}});
        cover_flags();
        load_stream();
        drain_blocks(0);
    endtask

    task automatic test_sparse();
        clear_layer();
        rand_flags(2 * FLG_PER_WORD);
        cover_flags();
        load_stream();
        drain_blocks(0);
    endtask

    task automatic test_zero_block();
        clear_layer();
        flag_list = '{12'h000, 12'hFFF, 12'h000, 12'h0F0, 12'h000, 12'h000, 12'h801, 12'h000};
        cover_flags();
        load_stream();
        drain_blocks(0);
    endtask

    task automatic test_backpressure();
        dense_blk_t held_dat;
        flag_blk_t  held_flag;
        clear_layer();
        rand_flags(FLG_PER_WORD);
        cover_flags();
        load_stream();
        take_block(0);
        while (blk_rdy !== 1'b1) begin
            next_cycle();
        end
        held_dat  = blk_dat;
        held_flag = blk_flag;
        repeat (100) begin
            next_cycle();
            check_level(blk_rdy, 1'b1, "blk_rdy while blk_get withheld");
            check_block(blk_dat, held_dat, "held blk_dat");
            check_flag(blk_flag, held_flag, "held blk_flag");
        end
        drain_blocks(1);
    endtask

    task automatic test_clear_mid();
        clear_layer();
        repeat (FLG_PER_WORD) flag_list.push_back({`BLOCK_DEPTH{1'b1}});
        cover_flags();
        load_stream();
        take_block(0);
        while (blk_rdy !== 1'b1) begin
            next_cycle();
        end
        clear_layer();
        repeat (20) begin
            check_level(blk_rdy, 1'b0, "blk_rdy after layer_clr");
            next_cycle();
        end
        rand_flags(FLG_PER_WORD);
        cover_flags();
        load_stream();
        drain_blocks(0);
    endtask

    initial begin
        layer_clr   = 1'b0;
        act_en_wr   = 1'b0;
        act_addr_wr = '0;
        act_dat_wr  = '0;
        flg_en_wr   = 1'b0;
        flg_addr_wr = '0;
        flg_dat_wr  = '0;
        blk_get     = 1'b0;
        lfsr_q      = 16'd42360;
        @(posedge rst_n);
        next_cycle();
        test_idle();
        test_dense();
        test_sparse();
        test_zero_block();
        test_backpressure();
        test_clear_mid();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+src
src/act_pkg.sv
src/act_gbf.sv
src/word_unpacker.sv
src/block_assembler.sv
src/act_dispatch_top.sv
verification/tb_clock_gen.sv
verification/tb_act_dispatch.sv

// File: Bender.yml
package:
  name: act_dispatch

sources:
  - include_dirs:
      - src
    files:
      - src/act_pkg.sv
      - src/act_gbf.sv
      - src/word_unpacker.sv
      - src/block_assembler.sv
      - src/act_dispatch_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_act_dispatch.sv
